/* hdl/soc_defines.svh */
// =========================================================================
// Bus widths, address map and RAM sizing of the SoC bus fabric
// Included by the package, the RTL and the testbench
// =========================================================================
`ifndef SOC_DEFINES_SVH
`define SOC_DEFINES_SVH

// Bus and line widths
`define SOC_ADDR_W 32
`define SOC_DATA_W 32
`define SOC_LINE_W 128

// Main RAM depth in bus words and single read latency in cycles
`define SOC_RAM_WORDS 1024
`define SOC_RAM_LAT 4

// Region bases, decoded on address bits 31:28
`define SOC_RAM_BASE 32'h8000_0000
`define SOC_CLINT_BASE 32'h3000_0000

// CLINT register offsets inside its region
`define SOC_CLINT_MSIP 16'h0000
`define SOC_CLINT_CMP_LO 16'h4000
`define SOC_CLINT_CMP_HI 16'h4004
`define SOC_CLINT_TIME_LO 16'hBFF8
`define SOC_CLINT_TIME_HI 16'hBFFC

// Wishbone cycle type tags
`define SOC_CTI_CLASSIC 3'b000
`define SOC_CTI_INCR 3'b010
`define SOC_CTI_EOB 3'b111

// Slaves behind the decoder
`define SOC_NUM_SLV 2

`endif

/* hdl/soc_pkg.sv */
// =========================================================================
// Shared types of the bus fabric
// Request and response structs travel between decoder, slaves and mux
// =========================================================================
`include "soc_defines.svh"

package soc_pkg;

  // =========================================================================
  // Plain vector types
  // =========================================================================

  // Byte address on the bus
  typedef logic [`SOC_ADDR_W-1:0] wb_addr_t;

  // One bus word
  typedef logic [`SOC_DATA_W-1:0] wb_data_t;

  // One select bit per byte lane
  typedef logic [`SOC_DATA_W/8-1:0] wb_sel_t;

  // Cycle type tag
  typedef logic [2:0] wb_cti_t;

  // One RAM cache line
  typedef logic [`SOC_LINE_W-1:0] line_t;

  // One-hot slave select, bit 0 RAM and bit 1 CLINT
  typedef logic [`SOC_NUM_SLV-1:0] slave_sel_t;

  // =========================================================================
  // Bus structs
  // =========================================================================

  // Master side of a Wishbone classic transfer
  typedef struct packed {
    logic     cyc;
    logic     stb;
    logic     we;
    wb_addr_t adr;
    wb_sel_t  sel;
    wb_data_t dat;
    wb_cti_t  cti;
  } wb_req_t;

  // Slave side, ack and err are one-cycle pulses
  typedef struct packed {
    wb_data_t dat;
    logic     ack;
    logic     err;
  } wb_rsp_t;

  // RAM slave FSM
  typedef enum logic [1:0] {
    RAM_IDLE,
    RAM_WAIT,
    RAM_BURST
  } ram_state_e;

endpackage

/* hdl/wb_addr_decode.sv */
// =========================================================================
// Address decoder of the bus fabric
// Turns the region nibble into a one-hot select and hands each slave
// a copy of the request whose cyc and stb only rise when it is selected
// =========================================================================
`timescale 1ns/1ps
`include "soc_defines.svh"

module wb_addr_decode (
  input  soc_pkg::wb_req_t    wb_req_i,
  output soc_pkg::wb_req_t    ram_req_o,
  output soc_pkg::wb_req_t    clint_req_o,
  output soc_pkg::slave_sel_t slave_sel_o
);

  // Region nibble position
  localparam int REGION_MSB = `SOC_ADDR_W - 1;
  localparam int REGION_LSB = `SOC_ADDR_W - 4;

  // Bases as typed constants so the nibble can be sliced
  localparam soc_pkg::wb_addr_t RAM_BASE   = `SOC_RAM_BASE;
  localparam soc_pkg::wb_addr_t CLINT_BASE = `SOC_CLINT_BASE;

  soc_pkg::slave_sel_t sel;
  logic [3:0]          region;

  assign region = wb_req_i.adr[REGION_MSB:REGION_LSB];

  // =========================================================================
  // Region compare
  // =========================================================================
  always_comb begin
    sel = '0;
    // Bit 0 RAM
    sel[0] = (region == RAM_BASE[REGION_MSB:REGION_LSB]);
    // Bit 1 CLINT
    sel[1] = (region == CLINT_BASE[REGION_MSB:REGION_LSB]);
  end

  // All zero for an unmapped address
  assign slave_sel_o = sel;

  // =========================================================================
  // Per-slave request copies
  // =========================================================================
  always_comb begin
    ram_req_o     = wb_req_i;
    ram_req_o.cyc = wb_req_i.cyc & sel[0];
    ram_req_o.stb = wb_req_i.stb & sel[0];
  end

  always_comb begin
    clint_req_o     = wb_req_i;
    clint_req_o.cyc = wb_req_i.cyc & sel[1];
    clint_req_o.stb = wb_req_i.stb & sel[1];
  end

endmodule

/* hdl/line_ram_slave.sv */
// =========================================================================
// Main RAM slave holding 128-bit lines behind a 32-bit Wishbone port
// Writes ack next cycle, reads wait the fixed latency and fill a line
// buffer that also serves the remaining beats of an INCR burst
// =========================================================================
`timescale 1ns/1ps
`include "soc_defines.svh"

module line_ram_slave (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  soc_pkg::wb_req_t req_i,
  output soc_pkg::wb_rsp_t rsp_o
);

  // =========================================================================
  // Geometry
  // =========================================================================
  localparam int WORDS_PER_LINE = `SOC_LINE_W / `SOC_DATA_W;
  localparam int NUM_LINES      = `SOC_RAM_WORDS / WORDS_PER_LINE;
  localparam int BYTES_PER_WORD = `SOC_DATA_W / 8;
  localparam int OFF_LSB        = $clog2(BYTES_PER_WORD);
  localparam int OFF_W          = $clog2(WORDS_PER_LINE);
  localparam int LINE_AW        = $clog2(NUM_LINES);
  localparam int CNT_W          = $clog2(`SOC_RAM_LAT);

  // Last count value before the read ack is registered
  localparam logic [CNT_W-1:0] LAT_LAST = CNT_W'(`SOC_RAM_LAT - 2);

  soc_pkg::line_t      mem_q [NUM_LINES];
  soc_pkg::line_t      line_buf_q;
  soc_pkg::ram_state_e state_q;
  soc_pkg::ram_state_e state_d;
  logic [CNT_W-1:0]    lat_cnt_q;
  logic                ack_q;
  logic [OFF_W-1:0]    word_off;
  logic [LINE_AW-1:0]  line_idx;
  logic                req_new;
  logic                wr_req;
  logic                rd_start;
  logic                lat_done;
  logic                burst_beat;

  // Word inside the line and line inside the RAM
  assign word_off = req_i.adr[OFF_LSB +: OFF_W];
  assign line_idx = req_i.adr[OFF_LSB + OFF_W +: LINE_AW];

  // Strobe not yet acknowledged
  assign req_new = req_i.cyc & req_i.stb & ~ack_q;

  assign wr_req     = (state_q == soc_pkg::RAM_IDLE) & req_new & req_i.we;
  assign rd_start   = (state_q == soc_pkg::RAM_IDLE) & req_new & ~req_i.we;
  assign lat_done   = (state_q == soc_pkg::RAM_WAIT) & (lat_cnt_q == LAT_LAST);
  assign burst_beat = (state_q == soc_pkg::RAM_BURST) & req_new;

  // =========================================================================
  // FSM
  // =========================================================================
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      soc_pkg::RAM_IDLE: begin
        if (rd_start) begin
          state_d = soc_pkg::RAM_WAIT;
        end
      end
      soc_pkg::RAM_WAIT: begin
        // INCR on the first beat opens a burst
        if (lat_done) begin
          state_d = (req_i.cti == `SOC_CTI_INCR) ? soc_pkg::RAM_BURST : soc_pkg::RAM_IDLE;
        end
      end
      soc_pkg::RAM_BURST: begin
        // EOB beat closes it, a dropped cycle aborts it
        if (!req_i.cyc || (burst_beat && req_i.cti == `SOC_CTI_EOB)) begin
          state_d = soc_pkg::RAM_IDLE;
        end
      end
      default: state_d = soc_pkg::RAM_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= soc_pkg::RAM_IDLE;
      lat_cnt_q <= '0;
      ack_q     <= 1'b0;
    end else begin
      state_q <= state_d;
      // One ack per strobe
      ack_q   <= wr_req | lat_done | burst_beat;
      if (rd_start) begin
        lat_cnt_q <= '0;
      end else if (state_q == soc_pkg::RAM_WAIT) begin
        lat_cnt_q <= lat_cnt_q + 1'b1;
      end
    end
  end

  // =========================================================================
  // Storage and line buffer
  // =========================================================================
  always_ff @(posedge clk_i) begin
    if (wr_req) begin
      // Byte merge into the addressed word of the line
      for (int b = 0; b < BYTES_PER_WORD; b++) begin
        if (req_i.sel[b]) begin
          mem_q[line_idx][word_off*`SOC_DATA_W + b*8 +: 8] <= req_i.dat[b*8 +: 8];
        end
      end
    end
    // Whole line captured with the first read ack
    if (lat_done) begin
      line_buf_q <= mem_q[line_idx];
    end
  end

  // Read word picked by the current beat's offset
  assign rsp_o = '{
    dat: line_buf_q[word_off*`SOC_DATA_W +: `SOC_DATA_W],
    ack: ack_q,
    err: 1'b0
  };

endmodule

/* hdl/clint_slave.sv */
// =========================================================================
// CLINT slave with mtime, mtimecmp and msip
// Registers are word accessed with byte selects, ack follows one cycle
// after the strobe, unknown offsets read as zero
// =========================================================================
`timescale 1ns/1ps
`include "soc_defines.svh"

module clint_slave (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  soc_pkg::wb_req_t req_i,
  output soc_pkg::wb_rsp_t rsp_o,
  output logic             timer_irq_o,
  output logic             sw_irq_o
);

  logic [63:0]       mtime_q;
  logic [63:0]       mtime_d;
  logic [63:0]       mtimecmp_q;
  logic              msip_q;
  logic              timer_irq_q;
  logic              ack_q;
  logic              wr_en;
  logic [15:0]       offset;
  soc_pkg::wb_data_t rdata;

  // Byte lane merge of a written word
  function automatic soc_pkg::wb_data_t merge_word(input soc_pkg::wb_data_t old_w,
                                                   input soc_pkg::wb_data_t new_w,
                                                   input soc_pkg::wb_sel_t  sel);
    soc_pkg::wb_data_t res;
    res = old_w;
    for (int b = 0; b < `SOC_DATA_W / 8; b++) begin
      if (sel[b]) begin
        res[b*8 +: 8] = new_w[b*8 +: 8];
      end
    end
    return res;
  endfunction

  assign offset = req_i.adr[15:0];
  assign wr_en  = req_i.cyc & req_i.stb & req_i.we & ~ack_q;

  // =========================================================================
  // mtime
  // =========================================================================
  always_comb begin
    mtime_d = mtime_q + 64'd1;
    // A written half overrides the increment
    if (wr_en && offset == `SOC_CLINT_TIME_LO) begin
      mtime_d[31:0] = merge_word(mtime_q[31:0], req_i.dat, req_i.sel);
    end
    if (wr_en && offset == `SOC_CLINT_TIME_HI) begin
      mtime_d[63:32] = merge_word(mtime_q[63:32], req_i.dat, req_i.sel);
    end
  end

  // =========================================================================
  // Registers and interrupts
  // =========================================================================
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mtime_q     <= '0;
      mtimecmp_q  <= '1;
      msip_q      <= 1'b0;
      timer_irq_q <= 1'b0;
      ack_q       <= 1'b0;
    end else begin
      mtime_q     <= mtime_d;
      ack_q       <= req_i.cyc & req_i.stb & ~ack_q;
      timer_irq_q <= (mtime_q >= mtimecmp_q);
      if (wr_en && offset == `SOC_CLINT_CMP_LO) begin
        mtimecmp_q[31:0] <= merge_word(mtimecmp_q[31:0], req_i.dat, req_i.sel);
      end
      if (wr_en && offset == `SOC_CLINT_CMP_HI) begin
        mtimecmp_q[63:32] <= merge_word(mtimecmp_q[63:32], req_i.dat, req_i.sel);
      end
      // Only bit 0 of msip exists
      if (wr_en && offset == `SOC_CLINT_MSIP && req_i.sel[0]) begin
        msip_q <= req_i.dat[0];
      end
    end
  end

  // Read mux
  always_comb begin
    unique case (offset)
      `SOC_CLINT_MSIP:    rdata = {31'd0, msip_q};
      `SOC_CLINT_CMP_LO:  rdata = mtimecmp_q[31:0];
      `SOC_CLINT_CMP_HI:  rdata = mtimecmp_q[63:32];
      `SOC_CLINT_TIME_LO: rdata = mtime_q[31:0];
      `SOC_CLINT_TIME_HI: rdata = mtime_q[63:32];
      default:            rdata = '0;
    endcase
  end

  assign rsp_o       = '{dat: rdata, ack: ack_q, err: 1'b0};
  assign timer_irq_o = timer_irq_q;
  assign sw_irq_o    = msip_q;

endmodule

/* hdl/wb_resp_mux.sv */
// =========================================================================
// Response multiplexer of the bus fabric
// Routes the selected slave's response back and answers unmapped
// strobes with a one-cycle err pulse
// =========================================================================
`timescale 1ns/1ps

module wb_resp_mux (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  soc_pkg::slave_sel_t slave_sel_i,
  input  soc_pkg::wb_req_t    req_i,
  input  soc_pkg::wb_rsp_t    ram_rsp_i,
  input  soc_pkg::wb_rsp_t    clint_rsp_i,
  output soc_pkg::wb_rsp_t    rsp_o
);

  logic err_q;
  logic unmapped;

  // Strobe with no slave behind it
  assign unmapped = req_i.cyc & req_i.stb & (slave_sel_i == '0);

  // Err pulse, not repeated for the same strobe
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_q <= 1'b0;
    end else begin
      err_q <= unmapped & ~err_q;
    end
  end

  always_comb begin
    rsp_o = '{dat: '0, ack: 1'b0, err: err_q};
    if (slave_sel_i[0]) begin
      // RAM
      rsp_o.dat = ram_rsp_i.dat;
      rsp_o.ack = ram_rsp_i.ack;
      rsp_o.err = err_q | ram_rsp_i.err;
    end else if (slave_sel_i[1]) begin
      // CLINT
      rsp_o.dat = clint_rsp_i.dat;
      rsp_o.ack = clint_rsp_i.ack;
      rsp_o.err = err_q | clint_rsp_i.err;
    end
  end

endmodule

/* hdl/soc_fabric_top.sv */
// =========================================================================
// Top level of the SoC bus fabric
// One Wishbone slave port feeding the decoder, the RAM and CLINT slaves
// and the response multiplexer, plus the CLINT interrupt lines
// =========================================================================
`timescale 1ns/1ps

module soc_fabric_top (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  soc_pkg::wb_req_t wb_req_i,
  output soc_pkg::wb_rsp_t wb_rsp_o,
  output logic             timer_irq_o,
  output logic             sw_irq_o
);

  // Per-slave requests and responses
  soc_pkg::wb_req_t    ram_req;
  soc_pkg::wb_req_t    clint_req;
  soc_pkg::wb_rsp_t    ram_rsp;
  soc_pkg::wb_rsp_t    clint_rsp;
  soc_pkg::slave_sel_t slave_sel;

  // =========================================================================
  // Decode
  // =========================================================================
  wb_addr_decode u_decode (
    .wb_req_i   (wb_req_i),
    .ram_req_o  (ram_req),
    .clint_req_o(clint_req),
    .slave_sel_o(slave_sel)
  );

  // =========================================================================
  // Slaves
  // =========================================================================
  line_ram_slave u_ram (
    .clk_i (clk_i),
    .rst_ni(rst_ni),
    .req_i (ram_req),
    .rsp_o (ram_rsp)
  );

  clint_slave u_clint (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (clint_req),
    .rsp_o      (clint_rsp),
    .timer_irq_o(timer_irq_o),
    .sw_irq_o   (sw_irq_o)
  );

  // =========================================================================
  // Response
  // =========================================================================
  wb_resp_mux u_resp_mux (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .slave_sel_i(slave_sel),
    .req_i      (wb_req_i),
    .ram_rsp_i  (ram_rsp),
    .clint_rsp_i(clint_rsp),
    .rsp_o      (wb_rsp_o)
  );

endmodule

/* tb/tb_clk_gen.sv */
// ===========================================================================
// Testbench clock and reset source
// 8 ns clock, active-low reset held for the first 8 cycles
// ===========================================================================
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  // Release just after an edge, like the other stimulus
  initial begin
    rst_no = 1'b0;
    repeat (8) @(posedge clk_o);
    #1 rst_no = 1'b1;
  end

endmodule

/* tb/soc_fabric_chk.sv */
// ===========================================================================
// Bus protocol and interrupt assertions, bound onto the fabric top level
// ===========================================================================
`timescale 1ns/1ps

module soc_fabric_chk (
  input logic             clk_i,
  input logic             rst_ni,
  input soc_pkg::wb_req_t wb_req_i,
  input soc_pkg::wb_rsp_t wb_rsp_i,
  input logic             timer_irq_i,
  input logic             sw_irq_i
);

  // Count of failed assertions
  int assert_fails = 0;

  // One response kind at a time
  a_ack_err_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(wb_rsp_i.ack && wb_rsp_i.err))
    else begin
      $error("ack and err high together");
      assert_fails++;
    end

  // Responses only inside a strobed cycle
  a_rsp_in_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (wb_rsp_i.ack || wb_rsp_i.err) |-> (wb_req_i.cyc && wb_req_i.stb))
    else begin
      $error("response outside cyc and stb");
      assert_fails++;
    end

  // No ack on back-to-back cycles
  a_ack_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_rsp_i.ack |=> !wb_rsp_i.ack)
    else begin
      $error("ack high on two consecutive cycles");
      assert_fails++;
    end

  // Quiet interrupts right after reset
  a_irq_reset: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> (!timer_irq_i && !sw_irq_i))
    else begin
      $error("interrupt high after reset release");
      assert_fails++;
    end

endmodule

/* tb/soc_fabric_tb.sv */
// ===========================================================================
// Self-checking testbench of the SoC bus fabric
// Acts as Wishbone master and checks RAM, CLINT and unmapped accesses
// against a behavioral model driven by seeded random stimulus
// ===========================================================================
`timescale 1ns/1ps
`include "soc_defines.svh"

module soc_fabric_tb;

  // ===========================================================================
  // Run constants
  // ===========================================================================
  localparam int N_RAND  = 64;
  localparam int N_BURST = 16;
  localparam int N_CLINT = 16;
  localparam int N_UNMAP = 8;
  localparam int LINES   = `SOC_RAM_WORDS / 4;
  // Worst case per transfer including the idle cycle
  localparam int XFER_MAX = `SOC_RAM_LAT + 3;
  localparam int NUM_XFER = `SOC_RAM_WORDS + 2 * N_RAND + 4 * N_BURST + N_CLINT
                            + 2 * N_UNMAP;
  localparam int TIMEOUT_CYC = 4 * (NUM_XFER * XFER_MAX + 8 + 8);
  localparam soc_pkg::wb_addr_t RAM_BASE   = `SOC_RAM_BASE;
  localparam soc_pkg::wb_addr_t CLINT_BASE = `SOC_CLINT_BASE;

  logic              clk_i;
  logic              rst_ni;
  soc_pkg::wb_req_t  wb_req;
  soc_pkg::wb_rsp_t  wb_rsp;
  logic              timer_irq;
  logic              sw_irq;
  integer            seed = 32'h97e6;
  int                value_errs = 0;
  int                proto_errs = 0;
  int                cycle_cnt = 0;
  // Reference model
  soc_pkg::wb_data_t ram_model [`SOC_RAM_WORDS];
  logic              msip_model;
  logic [63:0]       cmp_model;

  tb_clk_gen u_clk_gen (.clk_o(clk_i), .rst_no(rst_ni));

  soc_fabric_top u_dut (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .wb_req_i   (wb_req),
    .wb_rsp_o   (wb_rsp),
    .timer_irq_o(timer_irq),
    .sw_irq_o   (sw_irq)
  );

  bind soc_fabric_top soc_fabric_chk u_chk (
    .clk_i(clk_i), .rst_ni(rst_ni), .wb_req_i(wb_req_i), .wb_rsp_i(wb_rsp_o),
    .timer_irq_i(timer_irq_o), .sw_irq_i(sw_irq_o)
  );

  // ===========================================================================
  // Compare tasks and helpers
  // ===========================================================================
  task automatic check_word(input string name, input soc_pkg::wb_data_t got,
                            input soc_pkg::wb_data_t exp);
    if (got !== exp) begin
      value_errs++;
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      value_errs++;
      $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  // Byte lanes of new replace those of old where sel is set
  function automatic soc_pkg::wb_data_t apply_byte_sel(input soc_pkg::wb_data_t old,
                                                       input soc_pkg::wb_data_t new_w,
                                                       input soc_pkg::wb_sel_t sel);
    soc_pkg::wb_data_t res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) res[b*8 +: 8] = new_w[b*8 +: 8];
    end
    return res;
  endfunction

  function automatic soc_pkg::wb_addr_t ram_word_addr(input int word);
    return RAM_BASE + soc_pkg::wb_addr_t'(word * 4);
  endfunction

  // Single beat held until ack or err and released one edge later
  task automatic bus_beat(input logic we, input soc_pkg::wb_addr_t adr,
                          input soc_pkg::wb_sel_t sel, input soc_pkg::wb_data_t dat,
                          input soc_pkg::wb_cti_t cti, output soc_pkg::wb_data_t rdata,
                          output logic got_ack, output logic got_err);
    wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, sel: sel, dat: dat, cti: cti};
    @(negedge clk_i);
    while (!(wb_rsp.ack || wb_rsp.err)) @(negedge clk_i);
    rdata   = wb_rsp.dat;
    got_ack = wb_rsp.ack;
    got_err = wb_rsp.err;
    @(posedge clk_i);
    #1;
  endtask

  task automatic go_idle();
    wb_req = '0;
    @(posedge clk_i);
    #1;
  endtask

  // Single transfer with a check of the response kind
  task automatic bus_single(input logic we, input soc_pkg::wb_addr_t adr,
                            input soc_pkg::wb_sel_t sel, input soc_pkg::wb_data_t dat,
                            input logic expect_err, output soc_pkg::wb_data_t rdata);
    logic ack;
    logic err;
    bus_beat(we, adr, sel, dat, `SOC_CTI_CLASSIC, rdata, ack, err);
    go_idle();
    if (expect_err ? !(err && !ack) : !(ack && !err)) begin
      proto_errs++;
      $display("ERROR at %0t: access to %h ended in %s, expected %s", $time, adr,
               err ? "err" : "ack", expect_err ? "err" : "ack");
    end
    if (expect_err) check_flag("wb_rsp_o.ack", ack, 1'b0);
  endtask

  // Run limit
  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYC) begin
      $display("Timeout: run still busy after %0d cycles", cycle_cnt);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  // ===========================================================================
  // Test sequence
  // ===========================================================================
  initial begin
    soc_pkg::wb_data_t rdata;
    soc_pkg::wb_data_t data;
    soc_pkg::wb_data_t t0;
    soc_pkg::wb_addr_t adr;
    soc_pkg::wb_sel_t  sel;
    soc_pkg::wb_cti_t  cti;
    logic              we;
    logic              ack;
    logic              err;
    int                w;
    int                line;
    int                fails;
    wb_req     = '0;
    msip_model = 1'b0;
    cmp_model  = '1;
    @(posedge rst_ni);
    @(posedge clk_i);
    #1;
    // Known contents everywhere
    for (int i = 0; i < `SOC_RAM_WORDS; i++) begin
      data = $random(seed);
      bus_single(1'b1, ram_word_addr(i), 4'hF, data, 1'b0, rdata);
      ram_model[i] = data;
    end
    // Random byte-select writes with occasional read-back
    for (int i = 0; i < N_RAND; i++) begin
      w    = {$random(seed)} % `SOC_RAM_WORDS;
      data = $random(seed);
      sel  = soc_pkg::wb_sel_t'($random(seed));
      bus_single(1'b1, ram_word_addr(w), sel, data, 1'b0, rdata);
      ram_model[w] = apply_byte_sel(ram_model[w], data, sel);
      if ($random(seed) & 1) begin
        bus_single(1'b0, ram_word_addr(w), 4'hF, '0, 1'b0, rdata);
        check_word("wb_rsp_o.dat", rdata, ram_model[w]);
      end
    end
    // Four-beat line bursts
    for (int i = 0; i < N_BURST; i++) begin
      line = {$random(seed)} % LINES;
      for (int b = 0; b < 4; b++) begin
        cti = (b == 3) ? `SOC_CTI_EOB : `SOC_CTI_INCR;
        bus_beat(1'b0, ram_word_addr(line * 4 + b), 4'hF, '0, cti, rdata, ack, err);
        check_flag("wb_rsp_o.ack", ack, 1'b1);
        check_word("wb_rsp_o.dat", rdata, ram_model[line * 4 + b]);
      end
      go_idle();
    end
    // msip and sw_irq_o
    bus_single(1'b1, CLINT_BASE | `SOC_CLINT_MSIP, 4'hF, 32'd1, 1'b0, rdata);
    msip_model = 1'b1;
    check_flag("sw_irq_o", sw_irq, msip_model);
    bus_single(1'b0, CLINT_BASE | `SOC_CLINT_MSIP, 4'hF, '0, 1'b0, rdata);
    check_word("wb_rsp_o.dat", rdata, {31'd0, msip_model});
    bus_single(1'b1, CLINT_BASE | `SOC_CLINT_MSIP, 4'hF, 32'd0, 1'b0, rdata);
    msip_model = 1'b0;
    check_flag("sw_irq_o", sw_irq, msip_model);
    // mtimecmp both halves
    cmp_model = {$random(seed), $random(seed)};
    bus_single(1'b1, CLINT_BASE | `SOC_CLINT_CMP_LO, 4'hF, cmp_model[31:0], 1'b0, rdata);
    bus_single(1'b1, CLINT_BASE | `SOC_CLINT_CMP_HI, 4'hF, cmp_model[63:32], 1'b0, rdata);
    bus_single(1'b0, CLINT_BASE | `SOC_CLINT_CMP_LO, 4'hF, '0, 1'b0, rdata);
    check_word("wb_rsp_o.dat", rdata, cmp_model[31:0]);
    bus_single(1'b0, CLINT_BASE | `SOC_CLINT_CMP_HI, 4'hF, '0, 1'b0, rdata);
    check_word("wb_rsp_o.dat", rdata, cmp_model[63:32]);
    // Timer interrupt at compare zero and masked by all ones
    bus_single(1'b1, CLINT_BASE | `SOC_CLINT_CMP_LO, 4'hF, '0, 1'b0, rdata);
    bus_single(1'b1, CLINT_BASE | `SOC_CLINT_CMP_HI, 4'hF, '0, 1'b0, rdata);
    repeat (2) @(negedge clk_i);
    check_flag("timer_irq_o", timer_irq, 1'b1);
    @(posedge clk_i);
    #1;
    bus_single(1'b1, CLINT_BASE | `SOC_CLINT_CMP_HI, 4'hF, '1, 1'b0, rdata);
    bus_single(1'b1, CLINT_BASE | `SOC_CLINT_CMP_LO, 4'hF, '1, 1'b0, rdata);
    repeat (2) @(negedge clk_i);
    check_flag("timer_irq_o", timer_irq, 1'b0);
    @(posedge clk_i);
    #1;
    // mtime keeps counting
    bus_single(1'b0, CLINT_BASE | `SOC_CLINT_TIME_LO, 4'hF, '0, 1'b0, t0);
    bus_single(1'b0, CLINT_BASE | `SOC_CLINT_TIME_LO, 4'hF, '0, 1'b0, rdata);
    check_flag("wb_rsp_o.dat rising", rdata > t0, 1'b1);
    // Unmapped accesses leave the RAM untouched
    for (int i = 0; i < N_UNMAP; i++) begin
      do begin
        adr = $random(seed);
      end while (adr[31:28] == RAM_BASE[31:28] || adr[31:28] == CLINT_BASE[31:28]);
      we   = $random(seed) & 1;
      data = $random(seed);
      bus_single(we, adr, 4'hF, data, 1'b1, rdata);
      // No slave behind the address, so read data is zero
      if (!we) begin
        check_word("wb_rsp_o.dat", rdata, '0);
      end
      w = int'(adr[11:2]);
      bus_single(1'b0, ram_word_addr(w), 4'hF, '0, 1'b0, rdata);
      check_word("wb_rsp_o.dat", rdata, ram_model[w]);
    end
    fails = u_dut.u_chk.assert_fails;
    $display("Summary: %0d value errors, %0d protocol errors, %0d assertion failures",
             value_errs, proto_errs, fails);
    if (value_errs == 0 && proto_errs == 0 && fails == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* project.f */
+incdir+hdl
hdl/soc_pkg.sv
hdl/wb_addr_decode.sv
hdl/line_ram_slave.sv
hdl/clint_slave.sv
hdl/wb_resp_mux.sv
hdl/soc_fabric_top.sv
tb/tb_clk_gen.sv
tb/soc_fabric_chk.sv
tb/soc_fabric_tb.sv

/* Bender.yml */
package:
  name: soc_fabric

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/soc_pkg.sv
      - hdl/wb_addr_decode.sv
      - hdl/line_ram_slave.sv
      - hdl/clint_slave.sv
      - hdl/wb_resp_mux.sv
      - hdl/soc_fabric_top.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - tb/tb_clk_gen.sv
      - tb/soc_fabric_chk.sv
      - tb/soc_fabric_tb.sv
